// File: list.f
src/core_mem_pkg.sv
src/stat_bus_if.sv
src/mem_2rw.sv
src/mem_1r1w.sv
src/core_bus_bridge.sv
src/status_regs.sv
src/core_mem_top.sv
dv/core_mem_assertions.sv
dv/core_mem_checker.sv
dv/core_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module core_mem_tb -o core_mem_sim \
  || { echo "build failed"; exit 1; }

output="$(./obj_dir/core_mem_sim)"
echo "$output"
echo "$output" | grep -q "SIMULATION PASSED" \
  && echo "run finished without errors" \
  || { echo "run reported errors"; exit 1; }

// File: dv/core_mem_tb.sv
`timescale 1ns/1ps

module core_mem_tb;

  localparam int drain_limit = 50;       // cycles.
  localparam int run_limit   = 2_000_000; // ns.

  logic clk;
  logic core_reset;
  logic ibus_valid, ibus_rsp_valid;
  core_mem_pkg::core_addr_t ibus_pc;
  core_mem_pkg::word_t ibus_inst;
  logic dbus_valid, dbus_wr, dbus_rsp_valid;
  core_mem_pkg::core_addr_t dbus_addr;
  core_mem_pkg::acc_size_t dbus_size;
  core_mem_pkg::word_t dbus_wdata, dbus_rdata;
  logic data_dma_en, data_dma_ren;
  core_mem_pkg::strb_t data_dma_wen, ins_dma_we;
  core_mem_pkg::host_addr_t data_dma_addr, ins_dma_addr, stat_rd_addr;
  core_mem_pkg::line_t data_dma_wr_data, data_dma_rd_data, ins_dma_wr_data;
  logic stat_rd_en, status_update;
  core_mem_pkg::word_t stat_rd_data;

  logic ibus_chk, dbus_chk, dbus_rd, dma_chk, stat_chk, flag_chk, flag_exp;
  core_mem_pkg::word_t ibus_exp, dbus_exp, stat_exp;
  core_mem_pkg::line_t dma_exp;
  int error_count, check_count;
  logic busy;

  logic [7:0] imem_model [core_mem_pkg::imem_bytes];
  logic [7:0] dmem_model [core_mem_pkg::dmem_bytes];
  core_mem_pkg::word_t stat_model [core_mem_pkg::stat_regs];
  logic flag_model;
  integer seed;

  core_mem_top u_core_mem_top (.*);

  core_mem_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(run_limit);
    $display("timeout: the run did not reach its end in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  // expected line, read from the byte models.
  function automatic core_mem_pkg::line_t expect_line(input bit from_imem, input int addr);
    core_mem_pkg::line_t l;
    int base;
    base = addr & ~(core_mem_pkg::line_bytes - 1);
    for (int i = 0; i < core_mem_pkg::line_bytes; i++) begin
      l[i*8 +: 8] = from_imem ? imem_model[base+i] : dmem_model[base+i];
    end
    return l;
  endfunction

  function automatic core_mem_pkg::word_t expect_word(input bit from_imem, input int addr);
    core_mem_pkg::line_t l;
    l = expect_line(from_imem, addr);
    return addr[2] ? l[63:32] : l[31:0];
  endfunction

  function automatic logic [3:0] byte_mask(input logic [1:0] size, input logic [1:0] off);
    case (size)
      2'd0:    return 4'b0001 << off;
      2'd1:    return 4'b0011 << off;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic step();
    @(posedge clk);
    ibus_valid   <= 1'b0;
    dbus_valid   <= 1'b0;
    dbus_wr      <= 1'b0;
    data_dma_en  <= 1'b0;
    data_dma_ren <= 1'b0;
    data_dma_wen <= '0;
    ins_dma_we   <= '0;
    stat_rd_en   <= 1'b0;
    ibus_chk     <= 1'b0;
    dbus_chk     <= 1'b0;
    dbus_rd      <= 1'b0;
    dma_chk      <= 1'b0;
    stat_chk     <= 1'b0;
    flag_chk     <= 1'b1;
    flag_exp     <= flag_model;
  endtask

  task automatic load_imem(input int addr, input core_mem_pkg::line_t data, input logic [7:0] strb);
    ins_dma_we      <= strb;
    ins_dma_addr    <= 16'(addr);
    ins_dma_wr_data <= data;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) imem_model[(addr & ~7) + i] = data[i*8 +: 8];
    end
  endtask

  task automatic dma_write(input int addr, input core_mem_pkg::line_t data, input logic [7:0] strb);
    data_dma_en      <= 1'b1;
    data_dma_wen     <= strb;
    data_dma_addr    <= 16'(addr);
    data_dma_wr_data <= data;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) dmem_model[(addr & ~7) + i] = data[i*8 +: 8]; // host bytes land last.
    end
  endtask

  task automatic dma_read(input int addr);
    data_dma_en   <= 1'b1;
    data_dma_ren  <= 1'b1;
    data_dma_addr <= 16'(addr);
    dma_chk       <= 1'b1;
    dma_exp       <= expect_line(1'b0, addr);
  endtask

  task automatic fetch(input int pc);
    ibus_valid <= 1'b1;
    ibus_pc    <= pc;
    ibus_chk   <= 1'b1;
    ibus_exp   <= expect_word(1'b1, pc);
  endtask

  task automatic core_write(input int addr, input logic [1:0] size, input core_mem_pkg::word_t data);
    logic [3:0] mask;
    mask = byte_mask(size, addr[1:0]);
    dbus_valid <= 1'b1;
    dbus_wr    <= 1'b1;
    dbus_addr  <= addr;
    dbus_size  <= size;
    dbus_wdata <= data;
    dbus_chk   <= 1'b1;
    for (int b = 0; b < 4; b++) begin
      if (mask[b] && addr[15]) stat_model[addr[3:2]][b*8 +: 8] = data[b*8 +: 8];
      if (mask[b] && !addr[15]) dmem_model[(addr & 'h7ffc) + b] = data[b*8 +: 8];
    end
    if (addr[15]) begin
      flag_model = 1'b1;
      flag_exp  <= 1'b1;
    end
  endtask

  task automatic core_read(input int addr);
    dbus_valid <= 1'b1;
    dbus_wr    <= 1'b0;
    dbus_addr  <= addr;
    dbus_size  <= 2'd2;
    dbus_chk   <= 1'b1;
    dbus_rd    <= 1'b1;
    dbus_exp   <= addr[15] ? stat_model[addr[3:2]] : expect_word(1'b0, addr);
  endtask

  // call before core_write when both happen in one cycle.
  task automatic host_stat_read(input int idx);
    stat_rd_en   <= 1'b1;
    stat_rd_addr <= 16'(idx << 2);
    stat_chk     <= 1'b1;
    stat_exp     <= stat_model[idx];
    flag_model    = 1'b0;
    flag_exp     <= 1'b0;
  endtask

  initial begin
    int lines [16];
    int addr;
    int n;
    int assert_fails;
    seed = 32'heed1_b300;
    flag_model = 1'b0;
    for (int r = 0; r < core_mem_pkg::stat_regs; r++) stat_model[r] = '0;
    core_reset = 1'b1;
    {ibus_valid, dbus_valid, dbus_wr, data_dma_en, data_dma_ren, stat_rd_en} = '0;
    {ibus_pc, dbus_addr, dbus_size, dbus_wdata} = '0;
    {data_dma_wen, ins_dma_we, data_dma_addr, ins_dma_addr, stat_rd_addr} = '0;
    {data_dma_wr_data, ins_dma_wr_data} = '0;
    {ibus_chk, dbus_chk, dbus_rd, dma_chk, stat_chk, flag_chk, flag_exp} = '0;
    {ibus_exp, dbus_exp, stat_exp, dma_exp} = '0;
    repeat (5) @(posedge clk);
    core_reset <= 1'b0;

    for (int r = 0; r < 4; r++) begin // status bank is zero after reset.
      step();
      core_read(32'h8000 | (r << 2));
      host_stat_read(r);
    end

    for (int i = 0; i < 16; i++) begin // full line first, then a partial overwrite.
      lines[i] = (($random(seed) & 'h3ff) << 3);
      step();
      load_imem(lines[i], {$random(seed), $random(seed)}, 8'hff);
      step();
      load_imem(lines[i], {$random(seed), $random(seed)}, (i % 3 == 0) ? 8'($random(seed)) : 8'hff);
    end
    for (int i = 0; i < 16; i++) begin
      step();
      fetch(lines[i]);
      step();
      fetch(lines[i] + 4);
    end

    for (int l = 0; l < 32; l++) begin
      step();
      dma_write(l * 8, {$random(seed), $random(seed)}, 8'hff);
    end
    for (int l = 0; l < 32; l += 3) begin
      step();
      core_read(l * 8);
      step();
      core_read(l * 8 + 4);
    end

    for (int l = 0; l < 8; l++) begin
      for (int w = 0; w < 2; w++) begin
        for (int c = 0; c < 7; c++) begin
          addr = l * 8 + w * 4 + ((c < 4) ? c : ((c == 5) ? 2 : 0));
          step();
          core_write(addr, (c < 4) ? 2'd0 : ((c < 6) ? 2'd1 : 2'd2), $random(seed));
          step();
          dma_read(addr);
        end
      end
    end

    step();
    core_write(32'h8004, 2'd2, $random(seed));
    step();
    host_stat_read(1);
    step();
    core_write(32'h800a, 2'd1, $random(seed)); // half-word merge into register 2.
    step();
    host_stat_read(2);
    core_write(32'h800d, 2'd0, $random(seed));
    step();
    host_stat_read(3);
    step();
    host_stat_read(3);

    for (int r = 0; r < 4; r++) begin
      step();
      core_write(32'h8000 | (r << 2) | 1, 2'd0, $random(seed));
      step();
      core_read(32'h8000 | (r << 2));
      step();
      core_read(r << 2); // same low bits in the data memory.
    end

    for (int l = 40; l < 48; l++) begin
      step();
      dma_write(l * 8, {$random(seed), $random(seed)}, 8'hff);
      step();
      core_write(l * 8 + (l % 2) * 4, 2'd2, $random(seed));
      dma_write(l * 8, {$random(seed), $random(seed)}, 8'($random(seed)));
      step();
      dma_read(l * 8);
    end

    step();
    step();
    n = 0;
    while (busy && n < drain_limit) begin
      @(posedge clk);
      n++;
    end
    if (busy) begin
      $display("timeout: responses still pending at the end of the run");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      assert_fails = u_core_mem_top.u_assertions.fail_count;
      $display("checks %0d, errors %0d, assertion failures %0d",
               check_count, error_count, assert_fails);
      if (error_count == 0 && assert_fails == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

// File: dv/core_mem_checker.sv
`timescale 1ns/1ps

module core_mem_checker (
  input  logic                clk,
  input  logic                ibus_chk,
  input  core_mem_pkg::word_t ibus_exp,
  input  logic                ibus_rsp_valid,
  input  core_mem_pkg::word_t ibus_inst,
  input  logic                dbus_chk,
  input  logic                dbus_rd,
  input  core_mem_pkg::word_t dbus_exp,
  input  logic                dbus_rsp_valid,
  input  core_mem_pkg::word_t dbus_rdata,
  input  logic                dma_chk,
  input  core_mem_pkg::line_t dma_exp,
  input  core_mem_pkg::line_t data_dma_rd_data,
  input  logic                stat_chk,
  input  core_mem_pkg::word_t stat_exp,
  input  core_mem_pkg::word_t stat_rd_data,
  input  logic                flag_chk,
  input  logic                flag_exp,
  input  logic                status_update,
  output int                  error_count,
  output int                  check_count,
  output logic                busy
);

  logic                ibus_q = 1'b0;
  logic                dbus_q = 1'b0;
  logic                dbus_rd_q;
  logic                dma_q = 1'b0;
  logic                stat_q = 1'b0;
  logic                flag_q = 1'b0;
  core_mem_pkg::word_t ibus_exp_q;
  core_mem_pkg::word_t dbus_exp_q;
  core_mem_pkg::line_t dma_exp_q;
  core_mem_pkg::word_t stat_exp_q;
  logic                flag_exp_q;

  initial begin
    error_count = 0;
    check_count = 0;
  end

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  assign busy = ibus_q || dbus_q || dma_q || stat_q || ibus_chk || dbus_chk || dma_chk || stat_chk;

  // commands seen at edge N are compared at edge N+1, where the responses are stable.
  always @(posedge clk) begin
    if (ibus_q) begin
      compare("ibus_rsp_valid", 64'(ibus_rsp_valid), 64'd1);
      compare("ibus_inst", 64'(ibus_inst), 64'(ibus_exp_q));
    end
    if (dbus_q) begin
      compare("dbus_rsp_valid", 64'(dbus_rsp_valid), 64'd1);
      if (dbus_rd_q) compare("dbus_rdata", 64'(dbus_rdata), 64'(dbus_exp_q));
    end
    if (dma_q) compare("data_dma_rd_data", data_dma_rd_data, dma_exp_q);
    if (stat_q) compare("stat_rd_data", 64'(stat_rd_data), 64'(stat_exp_q));
    if (flag_q) compare("status_update", 64'(status_update), 64'(flag_exp_q));
    ibus_q     <= ibus_chk;
    ibus_exp_q <= ibus_exp;
    dbus_q     <= dbus_chk;
    dbus_rd_q  <= dbus_rd;
    dbus_exp_q <= dbus_exp;
    dma_q      <= dma_chk;
    dma_exp_q  <= dma_exp;
    stat_q     <= stat_chk;
    stat_exp_q <= stat_exp;
    flag_q     <= flag_chk;
    flag_exp_q <= flag_exp;
  end

endmodule

// File: dv/core_mem_assertions.sv
`timescale 1ns/1ps

module core_mem_assertions (
  input logic clk,
  input logic core_reset,
  input logic ibus_valid,
  input logic ibus_rsp_valid,
  input logic dbus_valid,
  input logic dbus_rsp_valid,
  input logic status_update
);

  int fail_count = 0;

  ibus_rsp_follows_cmd: assert property (@(posedge clk) disable iff (core_reset)
    ibus_valid |=> ibus_rsp_valid)
    else begin
      fail_count++;
      $error("ibus response missing one cycle after a fetch");
    end

  ibus_no_rsp_without_cmd: assert property (@(posedge clk) disable iff (core_reset)
    !ibus_valid |=> !ibus_rsp_valid)
    else begin
      fail_count++;
      $error("ibus response without a fetch");
    end

  dbus_rsp_follows_cmd: assert property (@(posedge clk) disable iff (core_reset)
    dbus_valid |=> dbus_rsp_valid)
    else begin
      fail_count++;
      $error("dbus response missing one cycle after a command");
    end

  dbus_no_rsp_without_cmd: assert property (@(posedge clk) disable iff (core_reset)
    !dbus_valid |=> !dbus_rsp_valid)
    else begin
      fail_count++;
      $error("dbus response without a command");
    end

  update_low_after_reset: assert property (@(posedge clk)
    core_reset |=> !status_update)
    else begin
      fail_count++;
      $error("status_update high after reset");
    end

endmodule

bind core_mem_top core_mem_assertions u_assertions (
  .clk            (clk),
  .core_reset     (core_reset),
  .ibus_valid     (ibus_valid),
  .ibus_rsp_valid (ibus_rsp_valid),
  .dbus_valid     (dbus_valid),
  .dbus_rsp_valid (dbus_rsp_valid),
  .status_update  (status_update)
);

// File: src/core_mem_top.sv
`timescale 1ns/1ps

module core_mem_top (
  input  logic                     clk,
  input  logic                     core_reset,

  input  logic                     ibus_valid,
  input  core_mem_pkg::core_addr_t ibus_pc,
  output logic                     ibus_rsp_valid,
  output core_mem_pkg::word_t      ibus_inst,

  input  logic                     dbus_valid,
  input  logic                     dbus_wr,
  input  core_mem_pkg::core_addr_t dbus_addr,
  input  core_mem_pkg::acc_size_t  dbus_size,
  input  core_mem_pkg::word_t      dbus_wdata,
  output logic                     dbus_rsp_valid,
  output core_mem_pkg::word_t      dbus_rdata,

  input  logic                     data_dma_en,
  input  logic                     data_dma_ren,
  input  core_mem_pkg::strb_t      data_dma_wen,
  input  core_mem_pkg::host_addr_t data_dma_addr,
  input  core_mem_pkg::line_t      data_dma_wr_data,
  output core_mem_pkg::line_t      data_dma_rd_data,

  input  core_mem_pkg::strb_t      ins_dma_we,
  input  core_mem_pkg::host_addr_t ins_dma_addr,
  input  core_mem_pkg::line_t      ins_dma_wr_data,

  input  logic                     stat_rd_en,
  input  core_mem_pkg::host_addr_t stat_rd_addr,
  output core_mem_pkg::word_t      stat_rd_data,
  output logic                     status_update
);

  logic                                  imem_en;
  logic [core_mem_pkg::imem_line_aw-1:0] imem_line_addr;
  core_mem_pkg::line_t                   imem_line;
  logic                                  dmem_en;
  core_mem_pkg::strb_t                   dmem_wen;
  logic [core_mem_pkg::dmem_line_aw-1:0] dmem_line_addr;
  core_mem_pkg::line_t                   dmem_wr_line;
  core_mem_pkg::line_t                   dmem_line;

  stat_bus_if stat_bus ();

  core_bus_bridge u_bridge (
    .clk            (clk),
    .core_reset     (core_reset),
    .ibus_valid     (ibus_valid),
    .ibus_pc        (ibus_pc),
    .ibus_rsp_valid (ibus_rsp_valid),
    .ibus_inst      (ibus_inst),
    .dbus_valid     (dbus_valid),
    .dbus_wr        (dbus_wr),
    .dbus_addr      (dbus_addr),
    .dbus_size      (dbus_size),
    .dbus_wdata     (dbus_wdata),
    .dbus_rsp_valid (dbus_rsp_valid),
    .dbus_rdata     (dbus_rdata),
    .imem_en        (imem_en),
    .imem_line_addr (imem_line_addr),
    .imem_line      (imem_line),
    .dmem_en        (dmem_en),
    .dmem_wen       (dmem_wen),
    .dmem_line_addr (dmem_line_addr),
    .dmem_wr_line   (dmem_wr_line),
    .dmem_line      (dmem_line),
    .stat           (stat_bus)
  );

  status_regs u_status_regs (
    .clk           (clk),
    .core_reset    (core_reset),
    .stat_rd_en    (stat_rd_en),
    .stat_rd_addr  (stat_rd_addr),
    .stat_rd_data  (stat_rd_data),
    .status_update (status_update),
    .stat          (stat_bus)
  );

  // port a belongs to the core, port b to the host DMA.
  mem_2rw #(
    .bytes_per_line (core_mem_pkg::line_bytes),
    .addr_width     (core_mem_pkg::dmem_line_aw)
  ) dmem (
    .clk   (clk),
    .ena   (dmem_en),
    .rena  (dmem_en),
    .wena  (dmem_wen),
    .addra (dmem_line_addr),
    .dina  (dmem_wr_line),
    .douta (dmem_line),
    .enb   (data_dma_en),
    .renb  (data_dma_ren),
    .wenb  (data_dma_wen),
    .addrb (data_dma_addr[core_mem_pkg::line_off_bits +: core_mem_pkg::dmem_line_aw]),
    .dinb  (data_dma_wr_data),
    .doutb (data_dma_rd_data)
  );

  mem_1r1w #(
    .bytes_per_line (core_mem_pkg::line_bytes),
    .addr_width     (core_mem_pkg::imem_line_aw)
  ) imem (
    .clk   (clk),
    .wea   (ins_dma_we),
    .addra (ins_dma_addr[core_mem_pkg::line_off_bits +: core_mem_pkg::imem_line_aw]),
    .dina  (ins_dma_wr_data),
    .enb   (imem_en),
    .addrb (imem_line_addr),
    .doutb (imem_line)
  );

endmodule

// File: src/status_regs.sv
`timescale 1ns/1ps

module status_regs (
  input  logic                     clk,
  input  logic                     core_reset,

  input  logic                     stat_rd_en,
  input  core_mem_pkg::host_addr_t stat_rd_addr,
  output core_mem_pkg::word_t      stat_rd_data,
  output logic                     status_update,

  stat_bus_if.regs                 stat
);

  core_mem_pkg::word_t       regs [core_mem_pkg::stat_regs];
  core_mem_pkg::stat_idx_t   host_idx;
  logic                      core_wr;
  logic                      core_rd;

  assign core_wr  = stat.sel && stat.wr;
  assign core_rd  = stat.sel && !stat.wr;
  assign host_idx = stat_rd_addr[core_mem_pkg::stat_idx_lsb +: $bits(core_mem_pkg::stat_idx_t)];

  always_ff @(posedge clk) begin
    if (core_reset) begin
      for (int r = 0; r < core_mem_pkg::stat_regs; r++) begin
        regs[r] <= '0;
      end
    end else if (core_wr) begin
      for (int b = 0; b < $bits(core_mem_pkg::word_mask_t); b++) begin
        if (stat.mask[b]) regs[stat.idx][b*8 +: 8] <= stat.wdata[b*8 +: 8];
      end
    end
  end

  // the core and the host each have their own read port.
  always_ff @(posedge clk) begin
    if (core_rd) stat.rdata <= regs[stat.idx];
  end

  always_ff @(posedge clk) begin
    if (stat_rd_en) stat_rd_data <= regs[host_idx];
  end

  // a new core write wins over a host read in the same cycle.
  always_ff @(posedge clk) begin
    if (core_reset) begin
      status_update <= 1'b0;
    end else if (core_wr) begin
      status_update <= 1'b1;
    end else if (stat_rd_en) begin
      status_update <= 1'b0;
    end
  end

endmodule

// File: src/core_bus_bridge.sv
`timescale 1ns/1ps

module core_bus_bridge (
  input  logic                                    clk,
  input  logic                                    core_reset,

  input  logic                                    ibus_valid,
  input  core_mem_pkg::core_addr_t                ibus_pc,
  output logic                                    ibus_rsp_valid,
  output core_mem_pkg::word_t                     ibus_inst,

  input  logic                                    dbus_valid,
  input  logic                                    dbus_wr,
  input  core_mem_pkg::core_addr_t                dbus_addr,
  input  core_mem_pkg::acc_size_t                 dbus_size,
  input  core_mem_pkg::word_t                     dbus_wdata,
  output logic                                    dbus_rsp_valid,
  output core_mem_pkg::word_t                     dbus_rdata,

  output logic                                    imem_en,
  output logic [core_mem_pkg::imem_line_aw-1:0]   imem_line_addr,
  input  core_mem_pkg::line_t                     imem_line,

  output logic                                    dmem_en,
  output core_mem_pkg::strb_t                     dmem_wen,
  output logic [core_mem_pkg::dmem_line_aw-1:0]   dmem_line_addr,
  output core_mem_pkg::line_t                     dmem_wr_line,
  input  core_mem_pkg::line_t                     dmem_line,

  stat_bus_if.bridge                              stat
);

  logic                     is_io;
  logic                     dmem_write;
  core_mem_pkg::word_mask_t word_mask;
  core_mem_pkg::strb_t      line_mask;
  logic                     ibus_word_q;
  logic                     dbus_word_q;
  logic                     dbus_io_q;
  core_mem_pkg::line_t      ibus_line_sh;
  core_mem_pkg::line_t      dbus_line_sh;

  always_ff @(posedge clk) begin
    if (core_reset) begin
      ibus_rsp_valid <= 1'b0;
      dbus_rsp_valid <= 1'b0;
    end else begin
      ibus_rsp_valid <= ibus_valid;
      dbus_rsp_valid <= dbus_valid; // writes get a response too.
    end
  end

  // remember where each response has to come from.
  always_ff @(posedge clk) begin
    if (ibus_valid) ibus_word_q <= ibus_pc[core_mem_pkg::word_sel_bit];
    if (dbus_valid) begin
      dbus_word_q <= dbus_addr[core_mem_pkg::word_sel_bit];
      dbus_io_q   <= is_io;
    end
  end

  assign imem_en        = ibus_valid;
  assign imem_line_addr = ibus_pc[core_mem_pkg::line_off_bits +: core_mem_pkg::imem_line_aw];
  assign ibus_line_sh   = imem_line >> {ibus_word_q, 5'd0};
  assign ibus_inst      = core_mem_pkg::word_t'(ibus_line_sh);

  // write data arrives already placed in its byte lanes, so only the mask
  // depends on the size and the low address bits.
  always_comb begin
    case (dbus_size)
      core_mem_pkg::size_byte: word_mask = 4'b0001 << dbus_addr[1:0];
      core_mem_pkg::size_half: word_mask = 4'b0011 << dbus_addr[1:0];
      default:                 word_mask = 4'b1111;
    endcase
  end

  assign is_io      = dbus_addr[core_mem_pkg::io_bit];
  assign dmem_write = dbus_valid && dbus_wr && !is_io;
  assign line_mask  = core_mem_pkg::strb_t'(word_mask)
                      << {dbus_addr[core_mem_pkg::word_sel_bit], 2'b00};

  assign dmem_en        = dbus_valid && !is_io;
  assign dmem_wen       = dmem_write ? line_mask : '0;
  assign dmem_line_addr = dbus_addr[core_mem_pkg::line_off_bits +: core_mem_pkg::dmem_line_aw];
  assign dmem_wr_line   = core_mem_pkg::line_t'(dbus_wdata)
                          << {dbus_addr[core_mem_pkg::word_sel_bit], 5'd0};

  assign stat.sel   = dbus_valid && is_io;
  assign stat.wr    = dbus_wr;
  assign stat.idx   = dbus_addr[core_mem_pkg::stat_idx_lsb +: $bits(core_mem_pkg::stat_idx_t)];
  assign stat.mask  = word_mask;
  assign stat.wdata = dbus_wdata;

  assign dbus_line_sh = dmem_line >> {dbus_word_q, 5'd0};
  assign dbus_rdata   = dbus_io_q ? stat.rdata : core_mem_pkg::word_t'(dbus_line_sh);

endmodule

// File: src/mem_1r1w.sv
`timescale 1ns/1ps

module mem_1r1w #(
  parameter int bytes_per_line = 8,
  parameter int addr_width     = 10
) (
  input  logic                        clk,

  input  logic [bytes_per_line-1:0]   wea,
  input  logic [addr_width-1:0]       addra,
  input  logic [8*bytes_per_line-1:0] dina,

  input  logic                        enb,
  input  logic [addr_width-1:0]       addrb,
  output logic [8*bytes_per_line-1:0] doutb
);

  logic [bytes_per_line-1:0][7:0] mem [2**addr_width];

  // a zero strobe means no write, so the port needs no separate enable.
  always_ff @(posedge clk) begin
    for (int i = 0; i < bytes_per_line; i++) begin
      if (wea[i]) mem[addra][i] <= dina[i*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (enb) doutb <= mem[addrb];
  end

endmodule

// File: src/mem_2rw.sv
`timescale 1ns/1ps

module mem_2rw #(
  parameter int bytes_per_line = 8,
  parameter int addr_width     = 12
) (
  input  logic                        clk,

  input  logic                        ena,
  input  logic                        rena,
  input  logic [bytes_per_line-1:0]   wena,
  input  logic [addr_width-1:0]       addra,
  input  logic [8*bytes_per_line-1:0] dina,
  output logic [8*bytes_per_line-1:0] douta,

  input  logic                        enb,
  input  logic                        renb,
  input  logic [bytes_per_line-1:0]   wenb,
  input  logic [addr_width-1:0]       addrb,
  input  logic [8*bytes_per_line-1:0] dinb,
  output logic [8*bytes_per_line-1:0] doutb
);

  logic [bytes_per_line-1:0][7:0] mem [2**addr_width];

  // port b is written last, so on a shared line its strobed bytes take priority.
  always_ff @(posedge clk) begin
    if (ena) begin
      for (int i = 0; i < bytes_per_line; i++) begin
        if (wena[i]) mem[addra][i] <= dina[i*8 +: 8];
      end
    end
    if (enb) begin
      for (int i = 0; i < bytes_per_line; i++) begin
        if (wenb[i]) mem[addrb][i] <= dinb[i*8 +: 8];
      end
    end
  end

  // reads return the line as it was before any write on the same edge.
  always_ff @(posedge clk) begin
    if (ena && rena) douta <= mem[addra];
  end

  always_ff @(posedge clk) begin
    if (enb && renb) doutb <= mem[addrb]; // holds until the next host read.
  end

endmodule

// File: src/stat_bus_if.sv
`timescale 1ns/1ps

interface stat_bus_if;

  logic                     sel;   // core access hits the status region.
  logic                     wr;
  core_mem_pkg::stat_idx_t  idx;
  core_mem_pkg::word_mask_t mask;
  core_mem_pkg::word_t      wdata;
  core_mem_pkg::word_t      rdata; // registered, valid the cycle after sel.

  modport bridge (
    output sel,
    output wr,
    output idx,
    output mask,
    output wdata,
    input  rdata
  );

  modport regs (
    input  sel,
    input  wr,
    input  idx,
    input  mask,
    input  wdata,
    output rdata
  );

endinterface

// File: src/core_mem_pkg.sv
package core_mem_pkg;

  localparam int line_bytes      = 8;
  localparam int line_bits       = 64;
  localparam int host_addr_width = 16;
  localparam int imem_bytes      = 8192;
  localparam int dmem_bytes      = 32768;
  localparam int stat_regs       = 4;
  localparam int io_bit          = 15; // data addresses with this bit set go to the status bank.

  localparam int line_off_bits = $clog2(line_bytes);
  localparam int imem_line_aw  = $clog2(imem_bytes / line_bytes);
  localparam int dmem_line_aw  = $clog2(dmem_bytes / line_bytes);
  localparam int word_sel_bit  = 2; // picks the upper or lower word of a line.
  localparam int stat_idx_lsb  = 2; // status index sits just above the byte offset.

  // access sizes as encoded on the data bus.
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  typedef logic [line_bits-1:0]       line_t;
  typedef logic [line_bytes-1:0]      strb_t;
  typedef logic [31:0]                word_t;
  typedef logic [3:0]                 word_mask_t;
  typedef logic [31:0]                core_addr_t;
  typedef logic [host_addr_width-1:0] host_addr_t;
  typedef logic [1:0]                 stat_idx_t;
  typedef logic [1:0]                 acc_size_t;

endpackage
